/* Makefile */
# Verilator build and run of the credit link testbench.
SIM  := obj_dir/credit_link_sim
SRCS := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv) credit_link_top.f

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS)
	verilator --binary --assert -j 0 --top-module credit_link_tb \
	  -f credit_link_top.f -Mdir obj_dir -o credit_link_sim

# The run passes only when the pass message shows up in the output.
run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee /dev/stderr | \
	  grep -x "Finished with no errors" > /dev/null

clean:
	rm -rf obj_dir

/* credit_link_top.f */
+incdir+hdl
hdl/credit_link_pkg.sv
hdl/credit_counter.sv
hdl/credit_sender.sv
hdl/credit_receiver.sv
hdl/link_reset_ctrl.sv
hdl/credit_link_top.sv
tb/credit_link_sva.sv
tb/credit_link_tb.sv

/* hdl/credit_counter.sv */
// Credit counter with reset load, live withhold and a one-step up/down update each cycle.
`timescale 1ns/1ns
`default_nettype none

`include "credit_link_settings.svh"

module credit_counter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        incr_valid,
  input  logic                        decr_valid,
  output logic                        decr_ready,
  input  credit_link_pkg::credit_cfg_t cfg,
  output credit_link_pkg::credit_t    value,
  output credit_link_pkg::credit_t    available
);

  // ------------------------------------------------------------
  // Available credit
  // ------------------------------------------------------------

  // Withheld credits are taken off the top of the stored count.
  // When the withhold is larger than the count nothing is available.
  always_comb begin
    if (value > cfg.credit_withhold) begin
      available = value - cfg.credit_withhold;
    end else begin
      available = '0;
    end
  end

  // A decrement is granted when a credit is on hand.
  // A credit that comes back this cycle can also be spent right away, so an
  // increment alone is enough to grant it.
  assign decr_ready = (available != '0) || incr_valid;

  // ------------------------------------------------------------
  // Count register
  // ------------------------------------------------------------

  logic decr_fire;
  logic at_max;

  assign decr_fire = decr_valid && decr_ready;

  // Returned credits beyond the maximum are not stored.
  assign at_max = (value == credit_link_pkg::credit_t'(`CL_MAX_CREDIT));

  // In reset the initial value is loaded every cycle and returned credits are dropped.
  // Otherwise the count moves by at most one.
  // An increment and a decrement in the same cycle leave the count where it is.
  always_ff @(posedge clk) begin
    if (rst) begin
      value <= cfg.credit_initial;
    end else if (incr_valid && !decr_fire) begin
      if (!at_max) begin
        value <= value + 1'b1;
      end
    end else if (decr_fire && !incr_valid) begin
      value <= value - 1'b1;
    end
  end

endmodule : credit_counter

`default_nettype wire

/* hdl/credit_link_pkg.sv */
// Credit link package holding the flit, credit count and credit configuration types.
`default_nettype none

`include "credit_link_settings.svh"

package credit_link_pkg;

  // Bits needed to count from zero up to and including the maximum credit.
  localparam int CREDIT_WIDTH = $clog2(`CL_MAX_CREDIT + 1);

  // One flit on the push, link and pop sides.
  // The last bit marks the final flit of a message and travels with the payload.
  typedef struct packed {
    logic [`CL_DATA_WIDTH-1:0] data;
    logic                      last;
  } flit_t;

  // Unsigned credit count, 0 through CL_MAX_CREDIT.
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  // Credit setup for the sender.
  // The initial value is loaded while the sender is in reset.
  // The withhold amount is live and keeps part of the credit out of circulation.
  typedef struct packed {
    credit_t credit_initial;
    credit_t credit_withhold;
  } credit_cfg_t;

endpackage : credit_link_pkg

`default_nettype wire

/* hdl/credit_link_settings.svh */
// Credit link settings: payload width, credit limit, receiver depth and link register option.
`ifndef CREDIT_LINK_SETTINGS_SVH
`define CREDIT_LINK_SETTINGS_SVH

// Payload bits carried by every flit, not counting the last marker.
`define CL_DATA_WIDTH 16

// Largest number of credits the sender counter can hold.
`define CL_MAX_CREDIT 8

// Number of flit entries in the receiver buffer.
// This must be at least CL_MAX_CREDIT, or a full set of credits could overflow the buffer.
`define CL_RECV_DEPTH 8

// Set to 1 to put a register stage on the sender's link outputs.
// With 0 the link is driven straight from the push handshake.
`define CL_REGISTER_POP 0

`endif

/* hdl/credit_link_top.sv */
// Credit link top level connecting the reset controller, sender and receiver.
`timescale 1ns/1ns
`default_nettype none

`include "credit_link_settings.svh"

module credit_link_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rx_rst,
  input  logic                        push_valid,
  input  credit_link_pkg::flit_t      push_flit,
  output logic                        push_ready,
  output logic                        pop_valid,
  output credit_link_pkg::flit_t      pop_flit,
  input  logic                        pop_ready,
  input  credit_link_pkg::credit_cfg_t credit_cfg,
  output credit_link_pkg::credit_t    credit_count,
  output credit_link_pkg::credit_t    credit_available,
  output logic                        link_up
);

  // ------------------------------------------------------------
  // Internal link
  // ------------------------------------------------------------

  logic                   sender_rst;
  logic                   receiver_rst;
  logic                   link_valid;
  credit_link_pkg::flit_t link_flit;
  logic                   link_credit;

  // Both side resets are joined here before they reach the two ends.
  link_reset_ctrl i_reset_ctrl (
    .clk          (clk),
    .rst          (rst),
    .rx_rst       (rx_rst),
    .sender_rst   (sender_rst),
    .receiver_rst (receiver_rst),
    .link_up      (link_up)
  );

  // Sender end.
  credit_sender #(
    .register_pop (1'(`CL_REGISTER_POP))
  ) i_sender (
    .clk              (clk),
    .rst              (sender_rst),
    .push_valid       (push_valid),
    .push_flit        (push_flit),
    .push_ready       (push_ready),
    .link_credit      (link_credit),
    .link_valid       (link_valid),
    .link_flit        (link_flit),
    .cfg              (credit_cfg),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  // Receiver end, the link has no ready since credit already guarantees room.
  credit_receiver i_receiver (
    .clk         (clk),
    .rst         (receiver_rst),
    .link_valid  (link_valid),
    .link_flit   (link_flit),
    .link_credit (link_credit),
    .pop_valid   (pop_valid),
    .pop_flit    (pop_flit),
    .pop_ready   (pop_ready)
  );

endmodule : credit_link_top

`default_nettype wire

/* hdl/credit_receiver.sv */
// Credit receiver buffering link flits in a FIFO and returning one credit per popped flit.
`timescale 1ns/1ns
`default_nettype none

`include "credit_link_settings.svh"

module credit_receiver (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   link_valid,
  input  credit_link_pkg::flit_t link_flit,
  output logic                   link_credit,
  output logic                   pop_valid,
  output credit_link_pkg::flit_t pop_flit,
  input  logic                   pop_ready
);

  localparam int DEPTH     = `CL_RECV_DEPTH;
  localparam int PTR_WIDTH = $clog2(DEPTH);
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  typedef logic [PTR_WIDTH-1:0] ptr_t;
  typedef logic [CNT_WIDTH-1:0] cnt_t;

  // Storage for the buffered flits.
  credit_link_pkg::flit_t mem [DEPTH];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  ptr_t wr_idx;
  cnt_t count;
  logic pop_fire;

  // Step a pointer by one, wrapping at the last entry.
  // The explicit wrap keeps depths that are not a power of two working.
  function automatic ptr_t ptr_next(input ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ------------------------------------------------------------
  // Pop side
  // ------------------------------------------------------------

  // The head entry is shown whenever the buffer holds something.
  // While this side is in reset nothing is offered.
  assign pop_valid = !rst && (count != '0);
  assign pop_flit  = mem[rd_ptr];
  assign pop_fire  = pop_valid && pop_ready;

  // ------------------------------------------------------------
  // Buffer write
  // ------------------------------------------------------------

  // The sender can leave reset one cycle before this side does, so a flit that
  // arrives during reset is kept in entry 0 while the pointers are cleared.
  assign wr_idx = rst ? '0 : wr_ptr;

  // The link has no ready, so every link flit is written.
  always_ff @(posedge clk) begin
    if (link_valid) begin
      mem[wr_idx] <= link_flit;
    end
  end

  // ------------------------------------------------------------
  // Pointers, occupancy and credit return
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr      <= '0;
      wr_ptr      <= link_valid ? ptr_t'(1) : '0;
      count       <= link_valid ? cnt_t'(1) : '0;
      link_credit <= 1'b0;
    end else begin
      if (link_valid) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop_fire) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // A write and a pop together leave the occupancy unchanged.
      if (link_valid && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !link_valid) begin
        count <= count - 1'b1;
      end
      // One credit goes back, a cycle later, for each entry that is freed.
      link_credit <= pop_fire;
    end
  end

endmodule : credit_receiver

`default_nettype wire

/* hdl/credit_sender.sv */
// Credit sender turning a ready/valid push stream into a credit-controlled link stream.
`timescale 1ns/1ns
`default_nettype none

module credit_sender #(
  // Set to 1 to register link_valid and link_flit.
  parameter bit register_pop = 1'b0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push_valid,
  input  credit_link_pkg::flit_t      push_flit,
  output logic                        push_ready,
  input  logic                        link_credit,
  output logic                        link_valid,
  output credit_link_pkg::flit_t      link_flit,
  input  credit_link_pkg::credit_cfg_t cfg,
  output credit_link_pkg::credit_t    credit_count,
  output credit_link_pkg::credit_t    credit_available
);

  logic decr_ready;
  logic send;

  // ------------------------------------------------------------
  // Credit tracking
  // ------------------------------------------------------------

  // Each returned credit is an increment, and each flit sent is a decrement.
  // The counter only spends a credit when its grant and push_valid are both high,
  // which is exactly the push handshake below.
  credit_counter i_counter (
    .clk        (clk),
    .rst        (rst),
    .incr_valid (link_credit),
    .decr_valid (push_valid),
    .decr_ready (decr_ready),
    .cfg        (cfg),
    .value      (credit_count),
    .available  (credit_available)
  );

  // No flit is taken while this side is in reset.
  // Outside reset the counter's grant decides, so a credit returned this cycle
  // can carry a flit in the same cycle.
  assign push_ready = !rst && decr_ready;

  // A flit goes out on the link for every push handshake.
  assign send = push_valid && push_ready;

  // ------------------------------------------------------------
  // Link outputs
  // ------------------------------------------------------------

  if (register_pop) begin : gen_reg_link
    // One cycle from push to link.
    // The flit register only loads on a send, so it holds between flits.
    always_ff @(posedge clk) begin
      if (rst) begin
        link_valid <= 1'b0;
      end else begin
        link_valid <= send;
      end
    end

    always_ff @(posedge clk) begin
      if (send) begin
        link_flit <= push_flit;
      end
    end
  end else begin : gen_pass_link
    // Cut-through, the push handshake drives the link in the same cycle.
    assign link_valid = send;
    assign link_flit  = push_flit;
  end

endmodule : credit_sender

`default_nettype wire

/* hdl/link_reset_ctrl.sv */
// Link reset controller joining both side resets and reporting when the link is up.
`timescale 1ns/1ns
`default_nettype none

module link_reset_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic rx_rst,
  output logic sender_rst,
  output logic receiver_rst,
  output logic link_up
);

  // ------------------------------------------------------------
  // Reset handshake
  // ------------------------------------------------------------

  // Each side's reset is flopped once before it reaches the other side.
  // The extra cycle is harmless here and keeps the cross paths short.
  logic rst_q;
  logic rx_rst_q;

  always_ff @(posedge clk) begin
    rst_q    <= rst;
    rx_rst_q <= rx_rst;
  end

  // A reset on either side resets both sides.
  // Sender credits and the receiver buffer then restart together, so no
  // credit is lost or counted twice.
  assign sender_rst   = rst || rx_rst_q;
  assign receiver_rst = rx_rst || rst_q;

  // ------------------------------------------------------------
  // Link status
  // ------------------------------------------------------------

  // The link is up one cycle after both sides are out of reset.
  // It drops one cycle after either side enters reset.
  always_ff @(posedge clk) begin
    if (sender_rst || receiver_rst) begin
      link_up <= 1'b0;
    end else begin
      link_up <= 1'b1;
    end
  end

endmodule : link_reset_ctrl

`default_nettype wire

/* tb/credit_link_sva.sv */
// Credit link assertions on credit limit, withhold, cross-side reset and pop stability.
`timescale 1ns/1ns
`default_nettype none

module credit_link_sva (
  input logic                         clk,
  input logic                         rst,
  input logic                         rx_rst,
  input logic                         sender_rst,
  input logic                         receiver_rst,
  input logic                         push_valid,
  input logic                         push_ready,
  input logic                         pop_valid,
  input logic                         pop_ready,
  input credit_link_pkg::flit_t       pop_flit,
  input credit_link_pkg::credit_cfg_t credit_cfg,
  input credit_link_pkg::credit_t     credit_count,
  input credit_link_pkg::credit_t     credit_available,
  input logic                         link_up
);

  // Failed assertions, read by the testbench at the end of the run.
  int unsigned fail_count = 0;
  logic [7:0]  outstanding;

  // Flits accepted at push and not yet popped.
  always_ff @(posedge clk) begin
    if (sender_rst || receiver_rst) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 8'(push_valid && push_ready) - 8'(pop_valid && pop_ready);
    end
  end

  // ------------------------------------------------------------
  // Credit limit and withhold
  // ------------------------------------------------------------

  a_credit_limit: assert property (@(posedge clk) disable iff (sender_rst || receiver_rst)
    outstanding <= 8'(credit_cfg.credit_initial))
    else begin
      fail_count++;
      $error("More flits in flight than initial credits");
    end

  // With every credit in flight and no pop last cycle, no credit can come back.
  a_credit_stall: assert property (@(posedge clk) disable iff (sender_rst || receiver_rst)
    (outstanding >= 8'(credit_cfg.credit_initial) && !$past(pop_ready)) |-> !push_ready)
    else begin
      fail_count++;
      $error("push_ready high with all credits in flight");
    end

  // Available and withheld credit add up to the stored count.
  // Once the withhold reaches the count nothing is left over.
  a_withhold: assert property (@(posedge clk) disable iff (sender_rst)
    ((credit_count >= credit_cfg.credit_withhold) ?
     (5'(credit_available) + 5'(credit_cfg.credit_withhold) == 5'(credit_count)) :
     (credit_available == '0)))
    else begin
      fail_count++;
      $error("credit_available does not match count less withhold");
    end

  a_no_credit: assert property (@(posedge clk) disable iff (sender_rst || receiver_rst)
    (credit_available == '0 && !$past(pop_ready) && !$past(pop_ready, 2)) |-> !push_ready)
    else begin
      fail_count++;
      $error("push_ready high with no credit available");
    end

  // ------------------------------------------------------------
  // Cross-side reset and pop side
  // ------------------------------------------------------------

  a_rx_reset: assert property (@(posedge clk) rx_rst |=> !push_ready && !link_up)
    else begin
      fail_count++;
      $error("Receiver reset did not stop the sender and the link");
    end

  a_tx_reset: assert property (@(posedge clk) rst |-> !push_ready ##1 !link_up)
    else begin
      fail_count++;
      $error("Sender reset did not stop pushes and the link");
    end

  a_rx_pop: assert property (@(posedge clk) rx_rst |-> !pop_valid)
    else begin
      fail_count++;
      $error("pop_valid high while the receiver is in reset");
    end

  // A held head flit stays put until it is taken.
  a_pop_stable: assert property (@(posedge clk) disable iff (receiver_rst)
    (pop_valid && !pop_ready) |=> receiver_rst || (pop_valid && $stable(pop_flit)))
    else begin
      fail_count++;
      $error("pop_flit changed while pop_ready was low");
    end

endmodule : credit_link_sva

bind credit_link_top credit_link_sva i_sva (.*);

`default_nettype wire

/* tb/credit_link_tb.sv */
// Credit link testbench driving random push and pop traffic with a flit scoreboard.
`timescale 1ns/1ns
`default_nettype none

`include "credit_link_settings.svh"

module credit_link_tb;

  // Cycles per test phase; the watchdog allows twice their sum.
  localparam int RUN_CYCLES    = 500;
  localparam int HOLD_CYCLES   = 400;
  localparam int FILL_CYCLES   = 30;
  localparam int RESET_RUN     = 250;
  localparam int SETTLE_CYCLES = 70;
  localparam int TEST_CYCLES   = RUN_CYCLES + HOLD_CYCLES + FILL_CYCLES
                                 + 2 * RESET_RUN + SETTLE_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
  localparam credit_link_pkg::credit_t INIT_CREDIT = credit_link_pkg::credit_t'(6);
  localparam credit_link_pkg::credit_t WITHHOLD    = credit_link_pkg::credit_t'(3);

  logic clk;
  logic rst;
  logic rx_rst;
  logic push_valid;
  logic push_ready;
  logic pop_valid;
  logic pop_ready;
  logic link_up;
  credit_link_pkg::flit_t       push_flit;
  credit_link_pkg::flit_t       pop_flit;
  credit_link_pkg::credit_cfg_t credit_cfg;
  credit_link_pkg::credit_t     credit_count;
  credit_link_pkg::credit_t     credit_available;
  credit_link_pkg::credit_t     withhold_req;

  integer seed = 32'h713f_cb9f;
  int     errors = 0;
  int     push_rate = 0;
  int     pop_rate = 0;
  bit     traffic_on = 1'b0;
  logic   push_taken = 1'b0;
  // Flits accepted at push, oldest first.
  credit_link_pkg::flit_t expected_q[$];

  credit_link_top i_dut (
    .clk              (clk),
    .rst              (rst),
    .rx_rst           (rx_rst),
    .push_valid       (push_valid),
    .push_flit        (push_flit),
    .push_ready       (push_ready),
    .pop_valid        (pop_valid),
    .pop_flit         (pop_flit),
    .pop_ready        (pop_ready),
    .credit_cfg       (credit_cfg),
    .credit_count     (credit_count),
    .credit_available (credit_available),
    .link_up          (link_up)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Ends a run that hangs.
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  task automatic check_credit(input credit_link_pkg::credit_t expected,
                              input credit_link_pkg::credit_t actual);
    assert (actual == expected) else begin
      errors++;
      $display("MISMATCH credit_count expected %h actual %h", expected, actual);
    end
  endtask

  // Pops are compared with the oldest accepted flit.
  task automatic check_pop();
    credit_link_pkg::flit_t exp_flit;
    if (expected_q.size() == 0) begin
      errors++;
      $display("Flit popped at %0t with none outstanding", $time);
    end else begin
      exp_flit = expected_q.pop_front();
      assert (pop_flit == exp_flit) else begin
        errors++;
        $display("MISMATCH pop_flit expected %h actual %h", exp_flit, pop_flit);
      end
    end
  endtask

  // ------------------------------------------------------------
  // Drive on the falling edge and sample once the outputs settle
  // ------------------------------------------------------------

  task automatic step();
    @(negedge clk);
    credit_cfg.credit_withhold = withhold_req;
    // A flit offered but not yet taken is held.
    if (!traffic_on) begin
      push_valid = 1'b0;
    end else if (push_taken || !push_valid) begin
      push_valid     = rand_pct() < push_rate;
      push_flit.data = `CL_DATA_WIDTH'($random(seed));
      push_flit.last = 1'($random(seed));
    end
    pop_ready = rand_pct() < pop_rate;
    #10;
    push_taken = push_valid && push_ready;
    if (push_taken) begin
      expected_q.push_back(push_flit);
    end
    if (pop_valid && pop_ready) begin
      check_pop();
    end
  endtask

  task automatic wait_link_up();
    int waited;
    waited = 0;
    while (!link_up && waited < 20) begin
      step();
      waited++;
    end
    if (!link_up) begin
      errors++;
      $display("Link stayed down 20 cycles after reset release");
    end
  endtask

  // Stop pushing, pop everything, then all credits must be home.
  task automatic drain_check();
    int waited;
    traffic_on = 1'b0;
    pop_rate = 100;
    waited = 0;
    while ((pop_valid || expected_q.size() != 0) && waited < 100) begin
      step();
      waited++;
    end
    if (waited >= 100) begin
      errors++;
      $display("Receiver did not drain, %0d flits missing", expected_q.size());
    end
    repeat (4) step();
    check_credit(credit_cfg.credit_initial, credit_count);
  endtask

  // Pulse one side's reset with the link quiet; the buffered flits are lost.
  task automatic side_reset(input bit rx_side);
    traffic_on = 1'b0;
    pop_rate = 0;
    repeat (2) step();
    @(negedge clk);
    if (rx_side) begin
      rx_rst = 1'b1;
    end else begin
      rst = 1'b1;
    end
    @(negedge clk);
    rx_rst = 1'b0;
    rst = 1'b0;
    wait_link_up();
    expected_q.delete();
    check_credit(credit_cfg.credit_initial, credit_count);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    rst = 1'b1;
    rx_rst = 1'b1;
    push_valid = 1'b0;
    push_flit = '0;
    pop_ready = 1'b0;
    withhold_req = '0;
    credit_cfg.credit_initial = INIT_CREDIT;
    credit_cfg.credit_withhold = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    rx_rst = 1'b0;
    wait_link_up();
    traffic_on = 1'b1;
    push_rate = 70;
    pop_rate = 60;
    repeat (RUN_CYCLES) step();
    // Withhold part of the credit with traffic still running.
    withhold_req = WITHHOLD;
    pop_rate = 30;
    repeat (HOLD_CYCLES) step();
    // Back-pressure until every credit is in flight.
    withhold_req = '0;
    push_rate = 100;
    pop_rate = 0;
    repeat (FILL_CYCLES) step();
    drain_check();
    side_reset(1'b1);
    traffic_on = 1'b1;
    push_rate = 60;
    pop_rate = 70;
    repeat (RESET_RUN) step();
    side_reset(1'b0);
    traffic_on = 1'b1;
    pop_rate = 70;
    repeat (RESET_RUN) step();
    drain_check();
    $display("Check errors: %0d, assertion failures: %0d", errors, i_dut.i_sva.fail_count);
    if (errors == 0 && i_dut.i_sva.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : credit_link_tb

`default_nettype wire
